/* rv_pkg.sv */
package rv_pkg;

    localparam int xlen = 32;

    typedef logic [4:0]      reg_addr_t;
    typedef logic [xlen-1:0] word_t;

    // major opcodes of the supported subset
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;

    // branch conditions
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    // alu groups shared by reg and imm forms
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    typedef enum logic [2:0] {
        cls_alu_reg,
        cls_alu_imm,
        cls_lui,
        cls_auipc,
        cls_branch,
        cls_jal,
        cls_jalr,
        cls_none      // anything else retires as a nop
    } inst_class_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_e;

    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // one instruction word seen five ways
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } inst_u;

    typedef struct packed {
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        reg_addr_t   rd;
        word_t       imm;
        inst_class_e cls;
        alu_op_e     alu_op;
        logic [2:0]  funct3;
        logic        wb_en;    // writes and rd != x0
    } decoded_t;

    typedef struct packed {
        logic      en;
        reg_addr_t addr;
        word_t     data;
    } rf_write_t;

    typedef struct packed {
        word_t     pc;
        word_t     next_pc;
        reg_addr_t rd;
        word_t     wdata;
        logic      wb;
    } retire_t;

endpackage

/* rv_alu.sv */
module rv_alu (
    input  rv_pkg::word_t   a,
    input  rv_pkg::word_t   b,
    input  rv_pkg::alu_op_e op,
    output rv_pkg::word_t   result
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = b[4:0];            // rv32 shifts use 5 bits
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (op)
            rv_pkg::alu_add:  result = a + b;
            rv_pkg::alu_sub:  result = a - b;
            rv_pkg::alu_sll:  result = a << shamt;
            rv_pkg::alu_slt: begin
                result = {{(rv_pkg::xlen - 1){1'b0}}, lt_signed};
            end
            rv_pkg::alu_sltu: begin
                result = {{(rv_pkg::xlen - 1){1'b0}}, lt_unsigned};
            end
            rv_pkg::alu_xor:  result = a ^ b;
            rv_pkg::alu_srl:  result = a >> shamt;
            rv_pkg::alu_sra:  result = $unsigned($signed(a) >>> shamt);  // sign fill
            rv_pkg::alu_or:   result = a | b;
            rv_pkg::alu_and:  result = a & b;
            default:          result = a + b;
        endcase
    end

endmodule

/* rv_decoder.sv */
module rv_decoder (
    input  rv_pkg::inst_u    inst,
    output rv_pkg::decoded_t decoded
);

    rv_pkg::inst_class_e cls;
    rv_pkg::word_t       imm;
    rv_pkg::alu_op_e     alu_op;
    logic                alt;       // funct7 bit 5 selects sub or sra

    assign alt = inst.r_fmt.funct7[5];

    always_comb begin
        case (inst.r_fmt.opcode)
            rv_pkg::op_reg:    cls = rv_pkg::cls_alu_reg;
            rv_pkg::op_imm:    cls = rv_pkg::cls_alu_imm;
            rv_pkg::op_lui:    cls = rv_pkg::cls_lui;
            rv_pkg::op_auipc:  cls = rv_pkg::cls_auipc;
            rv_pkg::op_branch: cls = rv_pkg::cls_branch;
            rv_pkg::op_jal:    cls = rv_pkg::cls_jal;
            rv_pkg::op_jalr:   cls = rv_pkg::cls_jalr;
            default:           cls = rv_pkg::cls_none;
        endcase
    end

    always_comb begin
        case (cls)
            rv_pkg::cls_alu_imm, rv_pkg::cls_jalr: begin
                imm = {{20{inst.i_fmt.imm_11_0[11]}}, inst.i_fmt.imm_11_0};
            end
            rv_pkg::cls_branch: begin
                imm = {{20{inst.b_fmt.imm_12}}, inst.b_fmt.imm_11,
                       inst.b_fmt.imm_10_5, inst.b_fmt.imm_4_1, 1'b0};
            end
            rv_pkg::cls_lui, rv_pkg::cls_auipc: begin
                imm = {inst.u_fmt.imm_31_12, 12'b0};   // low 12 bits zero
            end
            rv_pkg::cls_jal: begin
                imm = {{12{inst.j_fmt.imm_20}}, inst.j_fmt.imm_19_12,
                       inst.j_fmt.imm_11, inst.j_fmt.imm_10_1, 1'b0};
            end
            default: imm = '0;                  // r-type and nop
        endcase
    end

    always_comb begin
        alu_op = rv_pkg::alu_add;               // lui, auipc, jumps, branch target
        if (cls == rv_pkg::cls_alu_reg || cls == rv_pkg::cls_alu_imm) begin
            case (inst.r_fmt.funct3)
                rv_pkg::f3_add_sub: begin
                    // bit 30 belongs to the addi immediate so addi has no sub form
                    alu_op = (cls == rv_pkg::cls_alu_reg && alt) ? rv_pkg::alu_sub
                                                                 : rv_pkg::alu_add;
                end
                rv_pkg::f3_sll:     alu_op = rv_pkg::alu_sll;
                rv_pkg::f3_slt:     alu_op = rv_pkg::alu_slt;
                rv_pkg::f3_sltu:    alu_op = rv_pkg::alu_sltu;
                rv_pkg::f3_xor:     alu_op = rv_pkg::alu_xor;
                rv_pkg::f3_srl_sra: alu_op = alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
                rv_pkg::f3_or:      alu_op = rv_pkg::alu_or;
                default:            alu_op = rv_pkg::alu_and;
            endcase
        end
    end

    always_comb begin
        decoded.rs1    = inst.r_fmt.rs1;
        decoded.rs2    = inst.r_fmt.rs2;
        decoded.rd     = inst.r_fmt.rd;
        decoded.imm    = imm;
        decoded.cls    = cls;
        decoded.alu_op = alu_op;
        decoded.funct3 = inst.r_fmt.funct3;
        decoded.wb_en  = (cls != rv_pkg::cls_branch) && (cls != rv_pkg::cls_none) &&
                         (inst.r_fmt.rd != '0);   // x0 never written
    end

endmodule

/* rv_regfile.sv */
module rv_regfile (
    input  logic              clk,
    input  rv_pkg::reg_addr_t raddr1,
    input  rv_pkg::reg_addr_t raddr2,
    output rv_pkg::word_t     rdata1,
    output rv_pkg::word_t     rdata2,
    input  rv_pkg::rf_write_t wr
);

    rv_pkg::word_t regs [32];

    always_ff @(posedge clk) begin
        if (wr.en) begin
            regs[wr.addr] <= wr.data;
        end
    end

    // x0 reads as zero whatever entry 0 holds
    always_comb begin
        if (raddr1 == '0) begin
            rdata1 = '0;
        end else begin
            rdata1 = regs[raddr1];
        end
    end

    always_comb begin
        if (raddr2 == '0) begin
            rdata2 = '0;
        end else begin
            rdata2 = regs[raddr2];
        end
    end

endmodule

/* rv_execute.sv */
module rv_execute (
    input  rv_pkg::decoded_t  decoded,
    input  rv_pkg::word_t     src1,
    input  rv_pkg::word_t     src2,
    input  rv_pkg::word_t     pc,
    input  logic              accept,
    output rv_pkg::rf_write_t rf_write,
    output rv_pkg::word_t     next_pc,
    output rv_pkg::word_t     wdata
);

    rv_pkg::word_t alu_a;
    rv_pkg::word_t alu_b;
    rv_pkg::word_t alu_result;
    rv_pkg::word_t pc_plus4;
    logic          cond;                    // branch condition holds

    assign pc_plus4 = pc + 32'd4;

    always_comb begin
        case (decoded.cls)
            rv_pkg::cls_alu_imm, rv_pkg::cls_jalr: begin
                alu_a = src1;
                alu_b = decoded.imm;
            end
            rv_pkg::cls_alu_reg: begin
                alu_a = src1;
                alu_b = src2;
            end
            rv_pkg::cls_lui: begin
                alu_a = '0;
                alu_b = decoded.imm;
            end
            rv_pkg::cls_auipc, rv_pkg::cls_jal, rv_pkg::cls_branch: begin
                alu_a = pc;                     // pc-relative target
                alu_b = decoded.imm;
            end
            default: begin
                alu_a = '0;
                alu_b = '0;
            end
        endcase
    end

    rv_alu alu_i (
        .a      (alu_a),
        .b      (alu_b),
        .op     (decoded.alu_op),
        .result (alu_result)
    );

    always_comb begin
        case (decoded.funct3)
            rv_pkg::f3_beq:  cond = src1 == src2;
            rv_pkg::f3_bne:  cond = src1 != src2;
            rv_pkg::f3_blt:  cond = $signed(src1) < $signed(src2);
            rv_pkg::f3_bge:  cond = $signed(src1) >= $signed(src2);
            rv_pkg::f3_bltu: cond = src1 < src2;
            rv_pkg::f3_bgeu: cond = src1 >= src2;
            default:         cond = 1'b0;       // 010 / 011 never branch
        endcase
    end

    always_comb begin
        case (decoded.cls)
            rv_pkg::cls_branch: next_pc = cond ? alu_result : pc_plus4;
            rv_pkg::cls_jal:    next_pc = alu_result;
            rv_pkg::cls_jalr:   next_pc = {alu_result[rv_pkg::xlen-1:1], 1'b0};
            default:            next_pc = pc_plus4;
        endcase
    end

    // jumps write the link address and everything else the alu output
    assign wdata = (decoded.cls == rv_pkg::cls_jal || decoded.cls == rv_pkg::cls_jalr)
                   ? pc_plus4 : alu_result;

    assign rf_write.en   = decoded.wb_en & accept;
    assign rf_write.addr = decoded.rd;
    assign rf_write.data = wdata;

endmodule

/* rv_fetch.sv */
module rv_fetch #(
    parameter rv_pkg::word_t reset_pc = 32'h8000_0000
) (
    input  logic          clk,
    input  logic          reset,
    input  logic          inst_valid,
    input  logic          inst_ready,
    input  rv_pkg::word_t next_pc,
    output rv_pkg::word_t fetch_pc,
    output logic          accept
);

    rv_pkg::word_t pc;

    // the one place the instruction handshake is formed
    assign accept = inst_valid & inst_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= reset_pc;
        end else if (accept) begin
            pc <= next_pc;                      // holds while stalled
        end
    end

    assign fetch_pc = pc;

endmodule

/* rv_retire_reg.sv */
module rv_retire_reg (
    input  logic             clk,
    input  logic             reset,
    input  logic             accept,
    input  rv_pkg::word_t    pc,
    input  rv_pkg::word_t    next_pc,
    input  rv_pkg::word_t    wdata,
    input  rv_pkg::decoded_t decoded,
    output rv_pkg::retire_t  retire,
    output logic             retire_valid,
    input  logic             retire_ready,
    output logic             inst_ready
);

    rv_pkg::retire_t record;
    logic            full;

    // free now or freed by the transfer this cycle
    assign inst_ready = !full || retire_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            full <= 1'b0;
        end else if (accept) begin
            full <= 1'b1;                       // refill on same edge as drain
        end else if (retire_ready) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            record.pc      <= pc;
            record.next_pc <= next_pc;
            record.rd      <= decoded.rd;
            record.wdata   <= wdata;
            record.wb      <= decoded.wb_en;
        end
    end

    assign retire       = record;
    assign retire_valid = full;

endmodule

/* rv_core.sv */
module rv_core #(
    parameter rv_pkg::word_t reset_pc = 32'h8000_0000
) (
    input  logic            clk,
    input  logic            reset,
    output rv_pkg::word_t   fetch_pc,
    input  rv_pkg::inst_u   inst,
    input  logic            inst_valid,
    output logic            inst_ready,
    output rv_pkg::retire_t retire,
    output logic            retire_valid,
    input  logic            retire_ready
);

    logic              accept;
    rv_pkg::decoded_t  decoded;
    rv_pkg::word_t     src1;
    rv_pkg::word_t     src2;
    rv_pkg::rf_write_t rf_write;
    rv_pkg::word_t     next_pc;
    rv_pkg::word_t     wdata;

    rv_fetch #(
        .reset_pc (reset_pc)
    ) fetch_i (
        .clk        (clk),
        .reset      (reset),
        .inst_valid (inst_valid),
        .inst_ready (inst_ready),
        .next_pc    (next_pc),
        .fetch_pc   (fetch_pc),
        .accept     (accept)
    );

    rv_decoder decoder_i (
        .inst    (inst),
        .decoded (decoded)
    );

    rv_regfile regfile_i (
        .clk    (clk),
        .raddr1 (decoded.rs1),
        .raddr2 (decoded.rs2),
        .rdata1 (src1),
        .rdata2 (src2),
        .wr     (rf_write)
    );

    rv_execute execute_i (
        .decoded  (decoded),
        .src1     (src1),
        .src2     (src2),
        .pc       (fetch_pc),               // executing instruction sits at fetch_pc
        .accept   (accept),
        .rf_write (rf_write),
        .next_pc  (next_pc),
        .wdata    (wdata)
    );

    rv_retire_reg retire_reg_i (
        .clk          (clk),
        .reset        (reset),
        .accept       (accept),
        .pc           (fetch_pc),
        .next_pc      (next_pc),
        .wdata        (wdata),
        .decoded      (decoded),
        .retire       (retire),
        .retire_valid (retire_valid),
        .retire_ready (retire_ready),
        .inst_ready   (inst_ready)
    );

endmodule

/* rv_core_tb_program.svh */
// prog_image holds the instruction words from reset_pc upward with four per row
// expected_table holds {pc, next_pc, rd, wdata, wb} per retired instruction in execution order
`ifndef rv_core_tb_program_svh
`define rv_core_tb_program_svh

localparam int prog_len = 39;
localparam int exp_len  = 30;

// skipped slots hold addi x31, x0, 1 and must never retire
localparam rv_pkg::word_t prog_image [prog_len] = '{
    32'h0050_0093, 32'hffd0_0113, 32'h0020_81b3, 32'h4020_8233,   // 0x00
    32'h4011_52b3, 32'h0011_5333, 32'h0011_23b3, 32'h0011_3433,   // 0x10
    32'h0f00_c493, 32'h0040_9513, 32'h0015_65b3, 32'h00b4_f633,   // 0x20
    32'h1234_56b7, 32'h0000_1717, 32'h0010_8463, 32'h0010_0f93,   // 0x30
    32'h0020_8463, 32'h0020_9463, 32'h0010_0f93, 32'h0010_9463,   // 0x40
    32'h0011_4463, 32'h0010_0f93, 32'h0020_c463, 32'h0020_d463,   // 0x50
    32'h0010_0f93, 32'h0011_5463, 32'h0020_e463, 32'h0010_0f93,   // 0x60
    32'h0011_6463, 32'h0011_7463, 32'h0010_0f93, 32'h0020_f463,   // 0x70
    32'h00c0_07ef, 32'h0010_0f93, 32'h0010_0f93, 32'h0117_8867,   // 0x80
    32'h0010_0f93, 32'h0070_8013, 32'h0010_08b3                   // 0x90
};

localparam rv_pkg::retire_t expected_table [exp_len] = '{
    {32'h8000_0000, 32'h8000_0004, 5'd1,  32'h0000_0005, 1'b1},  // addi x1, x0, 5
    {32'h8000_0004, 32'h8000_0008, 5'd2,  32'hffff_fffd, 1'b1},  // addi x2, x0, -3
    {32'h8000_0008, 32'h8000_000c, 5'd3,  32'h0000_0002, 1'b1},  // add x3, x1, x2
    {32'h8000_000c, 32'h8000_0010, 5'd4,  32'h0000_0008, 1'b1},  // sub x4, x1, x2
    {32'h8000_0010, 32'h8000_0014, 5'd5,  32'hffff_ffff, 1'b1},  // sra x5, x2, x1
    {32'h8000_0014, 32'h8000_0018, 5'd6,  32'h07ff_ffff, 1'b1},  // srl x6, x2, x1
    {32'h8000_0018, 32'h8000_001c, 5'd7,  32'h0000_0001, 1'b1},  // slt x7, x2, x1
    {32'h8000_001c, 32'h8000_0020, 5'd8,  32'h0000_0000, 1'b1},  // sltu x8, x2, x1
    {32'h8000_0020, 32'h8000_0024, 5'd9,  32'h0000_00f5, 1'b1},  // xori x9, x1, 0xf0
    {32'h8000_0024, 32'h8000_0028, 5'd10, 32'h0000_0050, 1'b1},  // slli x10, x1, 4
    {32'h8000_0028, 32'h8000_002c, 5'd11, 32'h0000_0055, 1'b1},  // or x11, x10, x1
    {32'h8000_002c, 32'h8000_0030, 5'd12, 32'h0000_0055, 1'b1},  // and x12, x9, x11
    {32'h8000_0030, 32'h8000_0034, 5'd13, 32'h1234_5000, 1'b1},  // lui x13, 0x12345
    {32'h8000_0034, 32'h8000_0038, 5'd14, 32'h8000_1034, 1'b1},  // auipc x14, 0x1
    {32'h8000_0038, 32'h8000_0040, 5'd8,  32'h8000_0040, 1'b0},  // beq x1, x1 taken
    {32'h8000_0040, 32'h8000_0044, 5'd8,  32'h8000_0048, 1'b0},  // beq x1, x2
    {32'h8000_0044, 32'h8000_004c, 5'd8,  32'h8000_004c, 1'b0},  // bne x1, x2 taken
    {32'h8000_004c, 32'h8000_0050, 5'd8,  32'h8000_0054, 1'b0},  // bne x1, x1
    {32'h8000_0050, 32'h8000_0058, 5'd8,  32'h8000_0058, 1'b0},  // blt x2, x1 taken
    {32'h8000_0058, 32'h8000_005c, 5'd8,  32'h8000_0060, 1'b0},  // blt x1, x2
    {32'h8000_005c, 32'h8000_0064, 5'd8,  32'h8000_0064, 1'b0},  // bge x1, x2 taken
    {32'h8000_0064, 32'h8000_0068, 5'd8,  32'h8000_006c, 1'b0},  // bge x2, x1
    {32'h8000_0068, 32'h8000_0070, 5'd8,  32'h8000_0070, 1'b0},  // bltu x1, x2 taken
    {32'h8000_0070, 32'h8000_0074, 5'd8,  32'h8000_0078, 1'b0},  // bltu x2, x1
    {32'h8000_0074, 32'h8000_007c, 5'd8,  32'h8000_007c, 1'b0},  // bgeu x2, x1 taken
    {32'h8000_007c, 32'h8000_0080, 5'd8,  32'h8000_0084, 1'b0},  // bgeu x1, x2
    {32'h8000_0080, 32'h8000_008c, 5'd15, 32'h8000_0084, 1'b1},  // jal x15, +12
    {32'h8000_008c, 32'h8000_0094, 5'd16, 32'h8000_0090, 1'b1},  // jalr x16, x15, 17
    {32'h8000_0094, 32'h8000_0098, 5'd0,  32'h0000_000c, 1'b0},  // addi x0, x1, 7
    {32'h8000_0098, 32'h8000_009c, 5'd17, 32'h0000_0005, 1'b1}   // add x17, x0, x1
};

`endif

/* rv_core_tb.sv */
module rv_core_tb;

    localparam rv_pkg::word_t base_pc  = 32'h8000_0000;
    localparam rv_pkg::word_t nop_word = 32'h0000_0013;    // addi x0, x0, 0

    logic            clk;
    logic            reset;
    rv_pkg::word_t   fetch_pc;
    rv_pkg::inst_u   inst;
    logic            inst_valid;
    logic            inst_ready;
    rv_pkg::retire_t retire;
    logic            retire_valid;
    logic            retire_ready;

    logic [31:0]     rng;
    int              checked;         // records compared so far
    int              cycles;

    `include "rv_core_tb_program.svh"

    localparam int cycle_limit = 20 * exp_len + 100;

    rv_core #(
        .reset_pc (base_pc)
    ) dut_i (
        .clk          (clk),
        .reset        (reset),
        .fetch_pc     (fetch_pc),
        .inst         (inst),
        .inst_valid   (inst_valid),
        .inst_ready   (inst_ready),
        .retire       (retire),
        .retire_valid (retire_valid),
        .retire_ready (retire_ready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift_next(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // instruction memory model
    function automatic rv_pkg::word_t fetch_word(input rv_pkg::word_t addr);
        rv_pkg::word_t offset;
        int            idx;
        offset = addr - base_pc;
        idx    = int'(offset >> 2);
        if (offset[1:0] != 2'b00 || offset >= 32'(prog_len * 4)) begin
            return nop_word;              // outside the image
        end
        return prog_image[idx];
    endfunction

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        stop_run($sformatf("error: %s = %h, expected %h", name, got, exp));
    endtask

    task automatic check_word(input string name, input rv_pkg::word_t got,
                              input rv_pkg::word_t exp);
        if (got !== exp) begin
            report_mismatch(name, got, exp);
        end
    endtask

    task automatic check_retire(input rv_pkg::retire_t got, input rv_pkg::retire_t exp);
        if (got.pc !== exp.pc) begin
            report_mismatch("retire.pc", got.pc, exp.pc);
        end else if (got.next_pc !== exp.next_pc) begin
            report_mismatch("retire.next_pc", got.next_pc, exp.next_pc);
        end else if (got.rd !== exp.rd) begin
            report_mismatch("retire.rd", {27'b0, got.rd}, {27'b0, exp.rd});
        end else if (got.wdata !== exp.wdata) begin
            report_mismatch("retire.wdata", got.wdata, exp.wdata);
        end else if (got.wb !== exp.wb) begin
            report_mismatch("retire.wb", {31'b0, got.wb}, {31'b0, exp.wb});
        end
    endtask

    initial begin
        cycles = 0;
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles = cycles + 1;
        end
        stop_run($sformatf("run timed out after %0d cycles", cycles));
    end

    initial begin
        reset        = 1'b1;
        inst         = nop_word;
        inst_valid   = 1'b0;
        retire_ready = 1'b0;
        rng          = 32'hefd3_aa0e;
        checked      = 0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // a few idle cycles, nothing offered yet
        repeat (3) begin
            check_word("fetch_pc", fetch_pc, base_pc);
            if (retire_valid !== 1'b0) begin
                stop_run("a retire record appeared before any instruction was accepted");
            end
            if (inst_ready !== 1'b1) begin
                stop_run("inst_ready is not high while the core is idle after reset");
            end
            @(negedge clk);
        end

        while (checked < exp_len) begin
            rng          = xorshift_next(rng);
            inst_valid   = rng[0] | rng[1];            // offered 3 of 4 cycles
            retire_ready = rng[4] | rng[5];
            inst         = fetch_word(fetch_pc);
            if (retire_valid && retire_ready) begin    // transfers at the next rising edge
                check_retire(retire, expected_table[checked]);
                checked = checked + 1;
            end
            @(negedge clk);
        end

        $display("TESTS PASSED");
        $finish;
    end

endmodule

/* src.f */
+incdir+.
rv_pkg.sv
rv_alu.sv
rv_decoder.sv
rv_regfile.sv
rv_execute.sv
rv_fetch.sv
rv_retire_reg.sv
rv_core.sv
rv_core_tb.sv

/* run.sh */
#!/bin/sh
# build rv_core_tb with Verilator and run it; exit status is the simulation result

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f src.f --top-module rv_core_tb -o rv_core_tb_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/rv_core_tb_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
    exit "$status"
fi

exit 0
